/* verilog/pcpu_defs.svh */
`ifndef PCPU_DEFS_SVH
`define PCPU_DEFS_SVH

////////////////////////////////////////////////////////////
// datapath sizes
////////////////////////////////////////////////////////////

`define PCPU_DATA_W 32  // data, address and instruction word
`define PCPU_REG_W 5  // register index, 32 registers

////////////////////////////////////////////////////////////
// fetch
////////////////////////////////////////////////////////////

// first fetch address after reset
`define PCPU_RESET_PC 32'h0000_0000

// byte step between instructions
`define PCPU_PC_STEP 32'd4

`endif

/* verilog/pcpu_pkg.sv */
package pcpu_pkg;

`include "pcpu_defs.svh"

	typedef logic [`PCPU_DATA_W-1:0] word_t;  // data, address, instruction
	typedef logic [`PCPU_REG_W-1:0] reg_idx_t;  // register number

	// major opcodes, bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'h00,  // alu op in funct
		op_addi  = 6'h08,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// r-type function codes, bits 5:0
	typedef enum logic [5:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_nor = 6'h27,
		fn_slt = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,  // also address calc
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_nor = 3'd4,
		alu_slt = 3'd5,  // signed compare
		alu_lui = 3'd6  // imm to upper half
	} alu_op_t;

	// one word, two field layouts
	typedef union packed {
		struct packed {opcode_t opcode; reg_idx_t rs; reg_idx_t rt; reg_idx_t rd;
			logic [4:0] shamt; funct_t funct;} r;
		struct packed {opcode_t opcode; reg_idx_t rs; reg_idx_t rt; logic [15:0] imm;} i;
	} inst_t;

endpackage

/* verilog/pcpu_decode.sv */
`timescale 1ns/1ns
`include "pcpu_defs.svh"

module pcpu_decode (
	input  logic               clk,
	input  logic               rst,
	input  pcpu_pkg::word_t    inst_data,  // rom word for inst_addr
	input  logic               wb_wr,
	input  pcpu_pkg::reg_idx_t wb_dst,
	input  pcpu_pkg::word_t    wb_val,
	output pcpu_pkg::word_t    inst_addr,
	output logic               ex_valid,
	output pcpu_pkg::alu_op_t  ex_alu_op,
	output pcpu_pkg::reg_idx_t ex_rs,
	output pcpu_pkg::reg_idx_t ex_rt,
	output pcpu_pkg::word_t    ex_rs_val,
	output pcpu_pkg::word_t    ex_rt_val,
	output pcpu_pkg::word_t    ex_imm,
	output logic               ex_use_imm,
	output pcpu_pkg::reg_idx_t ex_dst,
	output logic               ex_wr,
	output logic               ex_load,
	output logic               ex_store
);

	pcpu_pkg::inst_t inst;
	pcpu_pkg::word_t rf [2**`PCPU_REG_W];  // register file
	pcpu_pkg::reg_idx_t rs;
	pcpu_pkg::reg_idx_t rt;
	pcpu_pkg::reg_idx_t dst;
	pcpu_pkg::word_t rs_val;
	pcpu_pkg::word_t rt_val;
	pcpu_pkg::word_t imm_sext;
	pcpu_pkg::word_t imm_zext;
	pcpu_pkg::word_t imm;
	pcpu_pkg::alu_op_t alu_op;
	logic use_imm;
	logic wr;
	logic load;
	logic store;
	logic uses_rs;
	logic uses_rt;
	logic stall;

	////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_addr <= `PCPU_RESET_PC;
		end else if (!stall) begin  // hold pc on load-use
			inst_addr <= inst_addr + `PCPU_PC_STEP;
		end
	end

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	assign inst = inst_data;
	assign rs = inst.r.rs;
	assign rt = inst.r.rt;
	assign imm_sext = {{(`PCPU_DATA_W-16){inst.i.imm[15]}}, inst.i.imm};
	assign imm_zext = {{(`PCPU_DATA_W-16){1'b0}}, inst.i.imm};

	always_comb begin
		alu_op = pcpu_pkg::alu_add;
		imm = imm_sext;  // arith and mem ops
		use_imm = 1'b1;
		dst = inst.i.rt;  // i-type writes rt
		wr = 1'b0;
		load = 1'b0;
		store = 1'b0;
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		case (inst.r.opcode)
			pcpu_pkg::op_rtype: begin
				use_imm = 1'b0;
				dst = inst.r.rd;
				wr = 1'b1;
				uses_rt = 1'b1;
				case (inst.r.funct)
					pcpu_pkg::fn_add: alu_op = pcpu_pkg::alu_add;
					pcpu_pkg::fn_sub: alu_op = pcpu_pkg::alu_sub;
					pcpu_pkg::fn_and: alu_op = pcpu_pkg::alu_and;
					pcpu_pkg::fn_or:  alu_op = pcpu_pkg::alu_or;
					pcpu_pkg::fn_nor: alu_op = pcpu_pkg::alu_nor;
					pcpu_pkg::fn_slt: alu_op = pcpu_pkg::alu_slt;
					default: wr = 1'b0;  // unknown funct acts as nop
				endcase
			end
			pcpu_pkg::op_addi: wr = 1'b1;
			pcpu_pkg::op_andi: begin
				alu_op = pcpu_pkg::alu_and;
				imm = imm_zext;
				wr = 1'b1;
			end
			pcpu_pkg::op_ori: begin
				alu_op = pcpu_pkg::alu_or;
				imm = imm_zext;
				wr = 1'b1;
			end
			pcpu_pkg::op_lui: begin
				alu_op = pcpu_pkg::alu_lui;
				imm = imm_zext;
				wr = 1'b1;
				uses_rs = 1'b0;  // rs field ignored
			end
			pcpu_pkg::op_lw: begin
				wr = 1'b1;
				load = 1'b1;
			end
			pcpu_pkg::op_sw: begin
				store = 1'b1;
				uses_rt = 1'b1;  // store data
			end
			default: uses_rs = 1'b0;
		endcase
	end

	// load in execute feeding this instruction
	assign stall = ex_load && (ex_dst != '0) &&
		((uses_rs && ex_dst == rs) || (uses_rt && ex_dst == rt));

	////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb_wr && wb_dst != '0) begin
			rf[wb_dst] <= wb_val;
		end
	end

	// write-first reads, r0 hardwired
	assign rs_val = (rs == '0) ? '0 : (wb_wr && wb_dst == rs) ? wb_val : rf[rs];
	assign rt_val = (rt == '0) ? '0 : (wb_wr && wb_dst == rt) ? wb_val : rf[rt];

	////////////////////////////////////////////////////////////
	// decode to execute register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_wr <= 1'b0;
			ex_load <= 1'b0;
			ex_store <= 1'b0;
		end else begin
			ex_valid <= !stall;  // bubble on stall
			ex_wr <= wr && !stall;
			ex_load <= load && !stall;
			ex_store <= store && !stall;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op <= alu_op;
		ex_rs <= rs;
		ex_rt <= rt;
		ex_rs_val <= rs_val;
		ex_rt_val <= rt_val;
		ex_imm <= imm;
		ex_use_imm <= use_imm;
		ex_dst <= dst;
	end

endmodule

/* verilog/pcpu_execute.sv */
`timescale 1ns/1ns

module pcpu_execute (
	input  logic               clk,
	input  logic               rst,
	input  logic               ex_valid,
	input  pcpu_pkg::alu_op_t  ex_alu_op,
	input  pcpu_pkg::reg_idx_t ex_rs,
	input  pcpu_pkg::reg_idx_t ex_rt,
	input  pcpu_pkg::word_t    ex_rs_val,
	input  pcpu_pkg::word_t    ex_rt_val,
	input  pcpu_pkg::word_t    ex_imm,
	input  logic               ex_use_imm,
	input  pcpu_pkg::reg_idx_t ex_dst,
	input  logic               ex_wr,
	input  logic               ex_load,
	input  logic               ex_store,
	input  logic               wb_wr,  // writeback forward
	input  pcpu_pkg::reg_idx_t wb_dst,
	input  pcpu_pkg::word_t    wb_val,
	output logic               mem_valid,
	output pcpu_pkg::word_t    mem_result,
	output pcpu_pkg::word_t    mem_store_val,
	output pcpu_pkg::reg_idx_t mem_dst,
	output logic               mem_wr,
	output logic               mem_load,
	output logic               mem_store
);

	pcpu_pkg::word_t a;  // forwarded rs
	pcpu_pkg::word_t rt_fwd;  // forwarded rt
	pcpu_pkg::word_t b;
	pcpu_pkg::word_t result;
	logic mem_fwd_en;
	logic wb_fwd_en;

	////////////////////////////////////////////////////////////
	// operand forwarding
	////////////////////////////////////////////////////////////

	// load data not ready in mem stage
	assign mem_fwd_en = mem_wr && !mem_load && (mem_dst != '0);
	assign wb_fwd_en = wb_wr && (wb_dst != '0);

	assign a = (mem_fwd_en && mem_dst == ex_rs) ? mem_result :
		(wb_fwd_en && wb_dst == ex_rs) ? wb_val : ex_rs_val;
	assign rt_fwd = (mem_fwd_en && mem_dst == ex_rt) ? mem_result :
		(wb_fwd_en && wb_dst == ex_rt) ? wb_val : ex_rt_val;
	assign b = ex_use_imm ? ex_imm : rt_fwd;

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	always_comb begin
		case (ex_alu_op)
			pcpu_pkg::alu_sub: result = a - b;
			pcpu_pkg::alu_and: result = a & b;
			pcpu_pkg::alu_or:  result = a | b;
			pcpu_pkg::alu_nor: result = ~(a | b);
			pcpu_pkg::alu_slt: result = pcpu_pkg::word_t'($signed(a) < $signed(b));
			pcpu_pkg::alu_lui: result = {b[15:0], 16'h0000};
			default: result = a + b;  // add, addi, lw/sw address, wraps
		endcase
	end

	////////////////////////////////////////////////////////////
	// execute to memory register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_valid <= 1'b0;
			mem_wr <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
		end else begin
			mem_valid <= ex_valid;
			mem_wr <= ex_wr;  // already zero in a bubble
			mem_load <= ex_load;
			mem_store <= ex_store;
		end
	end

	always_ff @(posedge clk) begin
		mem_result <= result;
		mem_store_val <= rt_fwd;  // sw data
		mem_dst <= ex_dst;
	end

endmodule

/* verilog/pcpu_mem_wb.sv */
`timescale 1ns/1ns

module pcpu_mem_wb (
	input  logic               clk,
	input  logic               rst,
	input  logic               mem_valid,
	input  pcpu_pkg::word_t    mem_result,  // alu result or address
	input  pcpu_pkg::word_t    mem_store_val,
	input  pcpu_pkg::reg_idx_t mem_dst,
	input  logic               mem_wr,
	input  logic               mem_load,
	input  logic               mem_store,
	input  pcpu_pkg::word_t    mem_data_in,  // read word, one clock late
	output pcpu_pkg::word_t    mem_addr,
	output pcpu_pkg::word_t    mem_data,
	output logic [3:0]         mem_we,
	output logic               mem_rd,
	output logic               wb_wr,
	output pcpu_pkg::reg_idx_t wb_dst,
	output pcpu_pkg::word_t    wb_val
);

	logic wb_load;
	pcpu_pkg::word_t wb_result;

	////////////////////////////////////////////////////////////
	// data memory port
	////////////////////////////////////////////////////////////

	assign mem_addr = mem_result;
	assign mem_data = mem_store_val;
	assign mem_we = {4{mem_valid && mem_store}};  // word stores only
	assign mem_rd = mem_valid && mem_load;

	////////////////////////////////////////////////////////////
	// memory to writeback register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_wr <= 1'b0;
			wb_load <= 1'b0;
		end else begin
			wb_wr <= mem_valid && mem_wr;
			wb_load <= mem_valid && mem_load;  // data arrives this cycle
		end
	end

	always_ff @(posedge clk) begin
		wb_dst <= mem_dst;
		wb_result <= mem_result;
	end

	// load word straight from the port
	assign wb_val = wb_load ? mem_data_in : wb_result;

endmodule

/* verilog/pcpu.sv */
`timescale 1ns/1ns

module pcpu (
	input  logic            clk,
	input  logic            rst,
	input  pcpu_pkg::word_t inst_data,
	input  pcpu_pkg::word_t mem_data_in,
	output pcpu_pkg::word_t inst_addr,
	output pcpu_pkg::word_t mem_addr,
	output pcpu_pkg::word_t mem_data,
	output logic [3:0]      mem_we,
	output logic            mem_rd
);

	// decode to execute
	logic ex_valid;
	pcpu_pkg::alu_op_t ex_alu_op;
	pcpu_pkg::reg_idx_t ex_rs;
	pcpu_pkg::reg_idx_t ex_rt;
	pcpu_pkg::word_t ex_rs_val;
	pcpu_pkg::word_t ex_rt_val;
	pcpu_pkg::word_t ex_imm;
	logic ex_use_imm;
	pcpu_pkg::reg_idx_t ex_dst;
	logic ex_wr;
	logic ex_load;
	logic ex_store;

	// execute to mem_wb
	logic mem_valid;
	pcpu_pkg::word_t mem_result;
	pcpu_pkg::word_t mem_store_val;
	pcpu_pkg::reg_idx_t mem_dst;
	logic mem_wr;
	logic mem_load;
	logic mem_store;

	// writeback, back to decode and execute
	logic wb_wr;
	pcpu_pkg::reg_idx_t wb_dst;
	pcpu_pkg::word_t wb_val;

	pcpu_decode decode_inst (.clk, .rst, .inst_data, .wb_wr, .wb_dst, .wb_val,
		.inst_addr, .ex_valid, .ex_alu_op, .ex_rs, .ex_rt, .ex_rs_val, .ex_rt_val,
		.ex_imm, .ex_use_imm, .ex_dst, .ex_wr, .ex_load, .ex_store);

	pcpu_execute execute_inst (.clk, .rst, .ex_valid, .ex_alu_op, .ex_rs, .ex_rt,
		.ex_rs_val, .ex_rt_val, .ex_imm, .ex_use_imm, .ex_dst, .ex_wr, .ex_load,
		.ex_store, .wb_wr, .wb_dst, .wb_val, .mem_valid, .mem_result,
		.mem_store_val, .mem_dst, .mem_wr, .mem_load, .mem_store);

	pcpu_mem_wb mem_wb_inst (.clk, .rst, .mem_valid, .mem_result, .mem_store_val,
		.mem_dst, .mem_wr, .mem_load, .mem_store, .mem_data_in, .mem_addr,
		.mem_data, .mem_we, .mem_rd, .wb_wr, .wb_dst, .wb_val);

endmodule

/* sim/pcpu_props.sv */
`timescale 1ns/1ns

module pcpu_props (
	input logic            clk,
	input logic            rst,
	input pcpu_pkg::word_t inst_addr,
	input logic [3:0]      mem_we,
	input logic            mem_rd
);

	// one data access per cycle
	no_rd_and_we: assert property (@(posedge clk) disable iff (rst)
		!(mem_rd && mem_we != 4'h0))
		else $error("mem_rd and mem_we active together");

	we_whole_word: assert property (@(posedge clk) disable iff (rst)
		(mem_we == 4'h0 || mem_we == 4'hf))
		else $error("mem_we is a partial byte mask");

	pc_aligned: assert property (@(posedge clk) disable iff (rst)
		inst_addr[1:0] == 2'b00)
		else $error("inst_addr not word aligned");

	quiet_in_reset: assert property (@(posedge clk)
		rst |=> (mem_we == 4'h0 && !mem_rd))
		else $error("memory access during reset");

endmodule

bind pcpu pcpu_props props_inst (.clk, .rst, .inst_addr, .mem_we, .mem_rd);

/* sim/tb_pcpu.sv */
`timescale 1ns/1ns
`include "pcpu_defs.svh"

module tb_pcpu;

	localparam pcpu_pkg::word_t NOP = 32'h0000_0020;  // add $0,$0,$0

	logic clk = 1'b0;
	logic rst = 1'b1;
	pcpu_pkg::word_t inst_data;
	pcpu_pkg::word_t mem_data_in = '0;
	pcpu_pkg::word_t inst_addr, mem_addr, mem_data;
	logic [3:0] mem_we;
	logic mem_rd;

	pcpu_pkg::word_t prog [64];  // instruction rom
	int prog_len = 0;
	pcpu_pkg::word_t ram [256];  // data ram indexed by addr[9:2]
	pcpu_pkg::word_t ref_mem [256];
	bit exp_store [$];  // expected access stream
	pcpu_pkg::word_t exp_addr [$];
	pcpu_pkg::word_t exp_data [$];
	int seen, errs, pass_cnt = 0, fail_cnt = 0;
	logic pend_rd, pend_we;
	pcpu_pkg::word_t pend_addr, pend_data;
	logic [31:0] seed = 32'd96039;
	longint cycle = 0, deadline = 1000;
	string cur_name = "startup";

	pcpu pcpu_inst (.clk, .rst, .inst_data, .mem_data_in, .inst_addr, .mem_addr,
		.mem_data, .mem_we, .mem_rd);

	always #50 clk = ~clk;

	// nops past the end of the program
	always_comb begin
		inst_data = (inst_addr[31:2] < prog_len) ? prog[inst_addr[7:2]] : NOP;
	end

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int unsigned rand_below(int unsigned m);
		seed = lcg_next(seed);
		return (seed >> 8) % m;  // low bits are weak
	endfunction

	function automatic pcpu_pkg::word_t enc_r(pcpu_pkg::funct_t fn, pcpu_pkg::reg_idx_t rd,
		pcpu_pkg::reg_idx_t rs, pcpu_pkg::reg_idx_t rt);
		pcpu_pkg::inst_t w;
		w.r.opcode = pcpu_pkg::op_rtype;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = '0;
		w.r.funct = fn;
		return w;
	endfunction

	function automatic pcpu_pkg::word_t enc_i(pcpu_pkg::opcode_t op, pcpu_pkg::reg_idx_t rt,
		pcpu_pkg::reg_idx_t rs, logic [15:0] imm);
		pcpu_pkg::inst_t w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	task automatic emit(pcpu_pkg::word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	////////////////////////////////////////////////////////////
	// reference interpreter
	////////////////////////////////////////////////////////////

	function automatic void ref_run();
		pcpu_pkg::word_t regs [32];
		pcpu_pkg::inst_t w;
		pcpu_pkg::word_t a, b, sx, zx, res;
		for (int k = 0; k < 32; k++) regs[k] = '0;
		for (int pc = 0; pc < prog_len; pc++) begin
			w = prog[pc];
			a = regs[w.i.rs];
			b = regs[w.i.rt];
			sx = {{16{w.i.imm[15]}}, w.i.imm};
			zx = {16'h0000, w.i.imm};
			case (w.r.opcode)
				pcpu_pkg::op_rtype: begin
					case (w.r.funct)
						pcpu_pkg::fn_add: res = a + b;
						pcpu_pkg::fn_sub: res = a - b;
						pcpu_pkg::fn_and: res = a & b;
						pcpu_pkg::fn_or:  res = a | b;
						pcpu_pkg::fn_nor: res = ~(a | b);
						default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
					regs[w.r.rd] = res;
				end
				pcpu_pkg::op_addi: regs[w.i.rt] = a + sx;  // wraps without trap
				pcpu_pkg::op_andi: regs[w.i.rt] = a & zx;
				pcpu_pkg::op_ori:  regs[w.i.rt] = a | zx;
				pcpu_pkg::op_lui:  regs[w.i.rt] = {w.i.imm, 16'h0000};
				pcpu_pkg::op_lw: begin
					exp_store.push_back(1'b0);
					exp_addr.push_back(a + sx);
					exp_data.push_back('0);
					regs[w.i.rt] = ref_mem[(a + sx) >> 2 & 8'hff];
				end
				pcpu_pkg::op_sw: begin
					exp_store.push_back(1'b1);
					exp_addr.push_back(a + sx);
					exp_data.push_back(b);
					ref_mem[(a + sx) >> 2 & 8'hff] = b;
				end
				default: ;
			endcase
			regs[0] = '0;  // r0 hardwired
		end
	endfunction

	////////////////////////////////////////////////////////////
	// memory model and checker
	////////////////////////////////////////////////////////////

	task automatic check_word(string name, pcpu_pkg::word_t got, pcpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			errs++;
		end
	endtask

	task automatic check_kind(logic got_store, bit exp_st);
		if (got_store !== exp_st) begin
			$display("FAIL t=%0t mem_we/mem_rd got %s expected %s", $time,
				got_store ? "store" : "load", exp_st ? "store" : "load");
			errs++;
		end
	endtask

	// outputs are settled mid-cycle
	always @(negedge clk) begin
		pend_rd = mem_rd;
		pend_we = (mem_we != 4'h0);
		pend_addr = mem_addr;
		pend_data = mem_data;
		if (mem_rd || mem_we != 4'h0) begin
			if (rst) begin
				$display("t=%0t a memory access appeared while reset was high", $time);
				errs++;
			end else if (seen >= exp_store.size()) begin
				$display("t=%0t surplus memory access at address %h", $time, mem_addr);
				errs++;
			end else begin
				check_kind(mem_we != 4'h0, exp_store[seen]);
				check_word("mem_addr", mem_addr, exp_addr[seen]);
				if (exp_store[seen]) check_word("mem_data", mem_data, exp_data[seen]);
				seen++;
			end
		end
	end

	always @(posedge clk) begin
		#1;
		if (pend_we) ram[pend_addr[9:2]] = pend_data;
		if (pend_rd) mem_data_in = ram[pend_addr[9:2]];  // one clock late
	end

	always @(posedge clk) begin
		cycle++;
		if (cycle > deadline) begin
			$display("timeout: test %s ran past its cycle budget", cur_name);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// test sequencing
	////////////////////////////////////////////////////////////

	task automatic begin_test(string name);
		@(posedge clk);
		#1 rst = 1'b1;
		cur_name = name;
		prog_len = 0;
	endtask

	task automatic run_test();
		int cyc;
		for (int k = 0; k < 256; k++) begin
			ram[k] = lcg_next(seed + k) ^ (k << 2);  // whole address in the pattern
			ref_mem[k] = ram[k];
		end
		seed = lcg_next(seed);
		exp_store.delete();
		exp_addr.delete();
		exp_data.delete();
		ref_run();
		seen = 0;
		errs = 0;
		deadline = cycle + prog_len * 2 + 60;
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		check_word("inst_addr", inst_addr, `PCPU_RESET_PC);  // first fetch address
		cyc = 0;
		while (seen < exp_store.size() && cyc < prog_len * 2 + 20) begin
			@(posedge clk);
			cyc++;
		end
		if (seen < exp_store.size()) begin
			$display("test %s is missing %0d expected memory accesses", cur_name,
				exp_store.size() - seen);
			errs++;
		end
		repeat (8) @(posedge clk);  // catch surplus accesses
		if (errs == 0) pass_cnt++;
		else fail_cnt++;
		$display("test %s: %0d accesses, %0d errors", cur_name, seen, errs);
	endtask

	task automatic random_program();
		int unsigned kind;
		pcpu_pkg::reg_idx_t d, s, t;
		for (int k = 1; k < 8; k++)
			emit(enc_i(pcpu_pkg::op_addi, k, 0, 16'(rand_below(65536))));
		repeat (40) begin
			kind = rand_below(12);
			d = pcpu_pkg::reg_idx_t'(rand_below(8));
			s = pcpu_pkg::reg_idx_t'(rand_below(8));
			t = pcpu_pkg::reg_idx_t'(rand_below(8));
			case (kind)
				0: emit(enc_r(pcpu_pkg::fn_add, d, s, t));
				1: emit(enc_r(pcpu_pkg::fn_sub, d, s, t));
				2: emit(enc_r(pcpu_pkg::fn_and, d, s, t));
				3: emit(enc_r(pcpu_pkg::fn_or, d, s, t));
				4: emit(enc_r(pcpu_pkg::fn_nor, d, s, t));
				5: emit(enc_r(pcpu_pkg::fn_slt, d, s, t));
				6: emit(enc_i(pcpu_pkg::op_addi, t, s, 16'(rand_below(65536))));
				7: emit(enc_i(pcpu_pkg::op_andi, t, s, 16'(rand_below(65536))));
				8: emit(enc_i(pcpu_pkg::op_ori, t, s, 16'(rand_below(65536))));
				9: emit(enc_i(pcpu_pkg::op_lui, t, 0, 16'(rand_below(65536))));
				10: emit(enc_i(pcpu_pkg::op_lw, t, 0, 16'(256 + 4 * rand_below(16))));
				default: emit(enc_i(pcpu_pkg::op_sw, t, 0, 16'(256 + 4 * rand_below(16))));
			endcase
		end
		for (int k = 1; k < 8; k++)  // dump final registers
			emit(enc_i(pcpu_pkg::op_sw, k, 0, 16'(320 + 4 * k)));
	endtask

	initial begin
		begin_test("reset");
		emit(enc_i(pcpu_pkg::op_sw, 0, 0, 16'h0100));  // store first
		emit(enc_i(pcpu_pkg::op_ori, 1, 0, 16'h55aa));
		emit(enc_i(pcpu_pkg::op_sw, 1, 0, 16'h0104));
		run_test();

		begin_test("rtype_chain");
		emit(enc_i(pcpu_pkg::op_ori, 1, 0, 16'h0f0f));
		emit(enc_i(pcpu_pkg::op_ori, 2, 0, 16'h00ff));
		emit(enc_r(pcpu_pkg::fn_nor, 3, 1, 2));
		emit(enc_r(pcpu_pkg::fn_add, 4, 3, 1));
		emit(enc_r(pcpu_pkg::fn_sub, 5, 4, 2));
		emit(enc_r(pcpu_pkg::fn_and, 6, 5, 3));
		emit(enc_r(pcpu_pkg::fn_or, 7, 6, 4));
		emit(enc_r(pcpu_pkg::fn_slt, 8, 7, 1));  // negative against positive
		for (int k = 3; k <= 8; k++) emit(enc_i(pcpu_pkg::op_sw, k, 0, 16'(256 + 4 * k)));
		run_test();

		begin_test("immediates");
		emit(enc_i(pcpu_pkg::op_addi, 1, 0, 16'hfffb));  // -5
		emit(enc_i(pcpu_pkg::op_andi, 2, 1, 16'h8f0f));
		emit(enc_i(pcpu_pkg::op_ori, 3, 0, 16'h8001));
		emit(enc_i(pcpu_pkg::op_lui, 4, 0, 16'h8765));
		emit(enc_i(pcpu_pkg::op_addi, 5, 4, 16'hffff));
		for (int k = 1; k <= 5; k++) emit(enc_i(pcpu_pkg::op_sw, k, 0, 16'(256 + 4 * k)));
		run_test();

		begin_test("load_use");
		emit(enc_i(pcpu_pkg::op_lw, 1, 0, 16'h0100));
		emit(enc_r(pcpu_pkg::fn_add, 2, 1, 1));  // needs the load at once
		emit(enc_i(pcpu_pkg::op_sw, 2, 0, 16'h0104));
		emit(enc_i(pcpu_pkg::op_lw, 3, 0, 16'h0108));
		emit(enc_i(pcpu_pkg::op_sw, 3, 0, 16'h010c));
		run_test();

		for (int n = 0; n < 5; n++) begin
			begin_test($sformatf("random_%0d", n));
			random_program();
			run_test();
		end

		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+verilog
verilog/pcpu_pkg.sv
verilog/pcpu_decode.sv
verilog/pcpu_execute.sv
verilog/pcpu_mem_wb.sv
verilog/pcpu.sv
sim/pcpu_props.sv
sim/tb_pcpu.sv

/* run.sh */
#!/bin/sh
# build and run the pcpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pcpu -f all.f -o tb_pcpu

./obj_dir/tb_pcpu > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
